// ==== fpFormatPkg.sv ====
// Binary32 field types, working widths and format constants
`default_nettype none

package fpFormatPkg;

    localparam int EXP_BIAS  = 127;
    localparam int EXP_MAX   = 255;
    localparam int SIG_WIDTH = 24;
    localparam int GRS_WIDTH = 3;

    // Stored fields of a binary32 word
    typedef logic [7:0]             fpExpT;
    typedef logic [SIG_WIDTH-2:0]   fpFracT;

    // Significand including the hidden one
    typedef logic [SIG_WIDTH-1:0]   fpSigT;

    // Significand followed by guard, round and sticky
    typedef logic [SIG_WIDTH+GRS_WIDTH-1:0] fpWideSigT;

    // Signed so that overflow and underflow stay visible
    typedef logic signed [9:0]      fpWideExpT;

    typedef struct packed {
        logic   sign;
        fpExpT  exponent;
        fpFracT fraction;
    } fp32T;

endpackage

`default_nettype wire

// ==== fpPipePkg.sv ====
// Pipeline stage structs, operation request and credit depths
`default_nettype none

package fpPipePkg;

    localparam int IN_CREDITS  = 4;
    localparam int OUT_CREDITS = 4;

    typedef logic [2:0] creditCntT;

    // Operation as handed in by the producer
    typedef struct packed {
        fpFormatPkg::fp32T a;
        fpFormatPkg::fp32T b;
        logic              sub;
    } fpOpReqT;

    // Alignment stage output, larger operand first
    typedef struct packed {
        logic                   sign;
        fpFormatPkg::fpWideExpT exponent;
        fpFormatPkg::fpWideSigT sigLarge;
        fpFormatPkg::fpWideSigT sigSmall;
        logic                   effSub;
        logic                   valid;
    } fpAlignedT;

    // Significand add output, carry already folded back
    typedef struct packed {
        logic                   sign;
        fpFormatPkg::fpWideExpT exponent;
        fpFormatPkg::fpWideSigT sig;
        logic                   valid;
    } fpSumT;

endpackage

`default_nettype wire

// ==== fpCreditIssue.sv ====
// Input request queue with upstream credit return and downstream credit gate
`default_nettype none
`timescale 1ns/1ps

module fpCreditIssue (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inValid,
    input  fpPipePkg::fpOpReqT inReq,
    output logic               inCredit,
    input  logic               outCredit,
    output logic               issueValid,
    output fpPipePkg::fpOpReqT issueReq
);
    import fpPipePkg::*;

    typedef logic [$clog2(IN_CREDITS)-1:0] qPtrT;

    fpOpReqT   queueMem [IN_CREDITS];
    qPtrT      wrPtr;
    qPtrT      rdPtr;
    creditCntT queueCnt;
    creditCntT outCreditCnt;
    logic      push;
    logic      pop;

    // Producer only sends while holding a credit so the queue has room
    assign push = inValid;

    // Issue needs a queued request and a downstream slot
    assign pop = (queueCnt != '0) && (outCreditCnt != '0);

    assign issueValid = pop;
    assign issueReq   = queueMem[rdPtr];

    // Freed slot goes straight back to the producer
    assign inCredit = pop;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            queueMem[wrPtr] <= inReq;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            queueCnt     <= '0;
            outCreditCnt <= creditCntT'(OUT_CREDITS);
        end
        else
        begin
            if (push)
            begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            queueCnt <= queueCnt + creditCntT'(push) - creditCntT'(pop);
            // Returned credit and a new issue may land together
            outCreditCnt <= outCreditCnt + creditCntT'(outCredit) - creditCntT'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== fpAlign.sv ====
// Operand unpack, denormal flush, magnitude ordering and sticky right shift
`default_nettype none
`timescale 1ns/1ps

module fpAlign (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 issueValid,
    input  fpPipePkg::fpOpReqT   issueReq,
    output fpPipePkg::fpAlignedT aligned
);
    import fpFormatPkg::*;
    import fpPipePkg::*;

    fp32T      opA;
    fp32T      opB;
    fp32T      opLarge;
    fp32T      opSmall;
    fpExpT     expDiff;
    fpSigT     sigLarge;
    fpSigT     sigSmall;
    logic      swapOps;
    logic [2*$bits(fpWideSigT)-1:0] shiftExt;
    fpAlignedT alignedD;

    // Zero exponent means zero or denormal, both become a signed zero
    function automatic fp32T flushOp(input fp32T op);
        fp32T res;
        res = op;
        if (op.exponent == '0)
        begin
            res.fraction = '0;
        end
        return res;
    endfunction

    always_comb
    begin
        opA = flushOp(issueReq.a);
        opB = flushOp(issueReq.b);
        opB.sign = opB.sign ^ issueReq.sub;

        // Exponent first and fraction second
        swapOps = {opB.exponent, opB.fraction} > {opA.exponent, opA.fraction};
        opLarge = swapOps ? opB : opA;
        opSmall = swapOps ? opA : opB;

        sigLarge = {opLarge.exponent != '0, opLarge.fraction};
        sigSmall = {opSmall.exponent != '0, opSmall.fraction};
        expDiff  = opLarge.exponent - opSmall.exponent;

        alignedD.sign     = opLarge.sign;
        alignedD.exponent = {2'b00, opLarge.exponent};
        alignedD.sigLarge = {sigLarge, {GRS_WIDTH{1'b0}}};
        alignedD.effSub   = opA.sign ^ opB.sign;
        alignedD.valid    = issueValid;

        // Lower half catches every bit pushed past the bottom
        shiftExt = '0;
        if (expDiff >= fpExpT'(SIG_WIDTH + GRS_WIDTH))
        begin
            alignedD.sigSmall = {{(SIG_WIDTH + GRS_WIDTH - 1){1'b0}}, |sigSmall};
        end
        else
        begin
            shiftExt = {sigSmall, {GRS_WIDTH{1'b0}}, {$bits(fpWideSigT){1'b0}}} >> expDiff;
            alignedD.sigSmall = shiftExt[2*$bits(fpWideSigT)-1:$bits(fpWideSigT)];
            alignedD.sigSmall[0] = alignedD.sigSmall[0] |
                                   (|shiftExt[$bits(fpWideSigT)-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            aligned.valid <= 1'b0;
        end
        else
        begin
            aligned <= alignedD;
        end
    end

endmodule

`default_nettype wire

// ==== fpAddMant.sv ====
// Significand add or subtract with carry-out fold and exponent increment
`default_nettype none
`timescale 1ns/1ps

module fpAddMant (
    input  logic                 clk,
    input  logic                 rstN,
    input  fpPipePkg::fpAlignedT aligned,
    output fpPipePkg::fpSumT     sum
);
    import fpFormatPkg::*;
    import fpPipePkg::*;

    logic [SIG_WIDTH+GRS_WIDTH:0] rawSum;
    fpSumT                        sumD;

    always_comb
    begin
        // Operands are ordered so the difference never goes negative
        if (aligned.effSub)
        begin
            rawSum = {1'b0, aligned.sigLarge} - {1'b0, aligned.sigSmall};
        end
        else
        begin
            rawSum = {1'b0, aligned.sigLarge} + {1'b0, aligned.sigSmall};
        end

        sumD.valid    = aligned.valid;
        sumD.sign     = aligned.sign;
        sumD.exponent = aligned.exponent;
        sumD.sig      = rawSum[SIG_WIDTH+GRS_WIDTH-1:0];

        // Carry out, shift right one and keep the dropped bit as sticky
        if (rawSum[SIG_WIDTH+GRS_WIDTH])
        begin
            sumD.sig      = {rawSum[SIG_WIDTH+GRS_WIDTH:2], rawSum[1] | rawSum[0]};
            sumD.exponent = aligned.exponent + fpWideExpT'(1);
        end

        // Exact zero is always +0
        if (rawSum == '0)
        begin
            sumD.sign = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            sum.valid <= 1'b0;
        end
        else
        begin
            sum <= sumD;
        end
    end

endmodule

`default_nettype wire

// ==== fpNormalize.sv ====
// Leading zero count, left shift, round to nearest even and result packing
`default_nettype none
`timescale 1ns/1ps

module fpNormalize (
    input  logic              clk,
    input  logic              rstN,
    input  fpPipePkg::fpSumT  sum,
    output logic              resultValid,
    output fpFormatPkg::fp32T result
);
    import fpFormatPkg::*;

    fpWideSigT          normSig;
    logic [4:0]         lzCount;
    fpSigT              mantTrunc;
    logic               guardBit;
    logic               roundBit;
    logic               stickyBit;
    logic               roundUp;
    logic [SIG_WIDTH:0] mantRound;
    fpWideExpT          normExp;
    fp32T               resultD;

    // Zeros above the top set bit, full width when empty
    function automatic logic [4:0] countZeros(input fpWideSigT value);
        for (int i = SIG_WIDTH + GRS_WIDTH - 1; i >= 0; i--)
        begin
            if (value[i])
            begin
                return 5'(SIG_WIDTH + GRS_WIDTH - 1 - i);
            end
        end
        return 5'(SIG_WIDTH + GRS_WIDTH);
    endfunction

    always_comb
    begin
        lzCount = countZeros(sum.sig);
        normSig = sum.sig << lzCount;

        mantTrunc = normSig[SIG_WIDTH+GRS_WIDTH-1:GRS_WIDTH];
        guardBit  = normSig[2];
        roundBit  = normSig[1];
        stickyBit = normSig[0];

        // Ties go to the even significand
        roundUp   = guardBit & (roundBit | stickyBit | mantTrunc[0]);
        mantRound = {1'b0, mantTrunc} + (SIG_WIDTH + 1)'(roundUp);

        // Rounding carry leaves a zero fraction and bumps the exponent
        normExp = sum.exponent - fpWideExpT'(lzCount) + fpWideExpT'(mantRound[SIG_WIDTH]);

        resultD.sign     = sum.sign;
        resultD.exponent = fpExpT'(normExp);
        resultD.fraction = mantRound[SIG_WIDTH-2:0];

        if ((sum.sig == '0) || (normExp <= 0))
        begin
            // Underflow flushes to a signed zero
            resultD.exponent = '0;
            resultD.fraction = '0;
        end
        else if (normExp >= fpWideExpT'(EXP_MAX))
        begin
            resultD.exponent = fpExpT'(EXP_MAX);
            resultD.fraction = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        result <= resultD;
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            resultValid <= 1'b0;
        end
        else
        begin
            resultValid <= sum.valid;
        end
    end

endmodule

`default_nettype wire

// ==== fpAddTop.sv ====
// Floating-point add unit top with credit issue and three pipeline stages
`default_nettype none
`timescale 1ns/1ps

module fpAddTop (
    input  logic               clk,
    input  logic               rstN,
    input  logic               inValid,
    input  fpPipePkg::fpOpReqT inReq,
    output logic               inCredit,
    output logic               outValid,
    output fpFormatPkg::fp32T  outResult,
    input  logic               outCredit
);
    import fpPipePkg::*;

    logic      issueValid;
    fpOpReqT   issueReq;
    fpAlignedT aligned;
    fpSumT     sum;

    fpCreditIssue issue0 (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inReq      (inReq),
        .inCredit   (inCredit),
        .outCredit  (outCredit),
        .issueValid (issueValid),
        .issueReq   (issueReq)
    );

    fpAlign align0 (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issueReq   (issueReq),
        .aligned    (aligned)
    );

    fpAddMant addMant0 (
        .clk     (clk),
        .rstN    (rstN),
        .aligned (aligned),
        .sum     (sum)
    );

    // Last stage registers the packed word
    fpNormalize normalize0 (
        .clk         (clk),
        .rstN        (rstN),
        .sum         (sum),
        .resultValid (outValid),
        .result      (outResult)
    );

endmodule

`default_nettype wire

// ==== fpAddChk.sv ====
// Bound assertions on the issue queue and the downstream credit counter
`default_nettype none
`timescale 1ns/1ps

module fpAddChk (
    input logic                 clk,
    input logic                 rstN,
    input logic                 inValid,
    input logic                 inCredit,
    input logic                 outCredit,
    input logic                 issueValid,
    input fpPipePkg::creditCntT queueCnt,
    input fpPipePkg::creditCntT outCreditCnt
);
    import fpPipePkg::*;

    int creditsHeld;

    // Downstream credits counted from returns and issues alone
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            creditsHeld <= OUT_CREDITS;
        end
        else
        begin
            creditsHeld <= creditsHeld + int'(outCredit) - int'(issueValid);
        end
    end

    // Issue consumes a downstream credit that must exist
    issueHasCredit: assert property (@(posedge clk) disable iff (!rstN)
        issueValid |-> (creditsHeld > 0))
        else $error("issue with no downstream credit");

    // A push into a full queue needs a pop in the same cycle
    noQueueOverflow: assert property (@(posedge clk) disable iff (!rstN)
        (inValid && (queueCnt == creditCntT'(IN_CREDITS))) |-> issueValid)
        else $error("request pushed into a full queue");

    countsInRange: assert property (@(posedge clk) disable iff (!rstN)
        (queueCnt <= creditCntT'(IN_CREDITS)) && (outCreditCnt <= creditCntT'(OUT_CREDITS)))
        else $error("queue or credit count out of range");

    // Quiet on the first cycle out of reset
    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (!inCredit && !issueValid && (queueCnt == '0)))
        else $error("credit or issue active right after reset");

endmodule

`default_nettype wire

// ==== fpAddTb.sv ====
// Testbench for the floating-point add unit with credit traffic and a reference model
`default_nettype none
`timescale 1ns/1ps

module fpAddTb;
    import fpFormatPkg::*;
    import fpPipePkg::*;

    localparam int NUM_RANDOM = 300;

    logic    clk;
    logic    rstN;
    logic    inValid;
    fpOpReqT inReq;
    logic    inCredit;
    logic    outValid;
    fp32T    outResult;
    logic    outCredit;

    fpOpReqT reqQ[$];
    fp32T    expQ[$];
    int      seed;
    int      totalOps;
    int      sentCount;
    int      doneCount;
    int      prodCredits;
    int      pendingCredits;
    logic    holdCredits;

    fpAddTop dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inReq     (inReq),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outResult (outResult),
        .outCredit (outCredit)
    );

    bind fpCreditIssue fpAddChk chk0 (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inCredit     (inCredit),
        .outCredit    (outCredit),
        .issueValid   (issueValid),
        .queueCnt     (queueCnt),
        .outCreditCnt (outCreditCnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on a failed check");
    endtask

    // Exact sum on a wide integer grid then one rounding to nearest even
    function automatic fp32T fpAddRef(input fpOpReqT req);
        fp32T        opL;
        fp32T        opS;
        fp32T        res;
        logic [23:0] sigL;
        logic [23:0] sigS;
        logic [65:0] total;
        logic [24:0] mant;
        int          diff;
        int          msb;
        int          resExp;
        opL = req.a;
        opS = req.b;
        opS.sign = opS.sign ^ req.sub;
        if ({opS.exponent, opS.fraction} > {opL.exponent, opL.fraction})
        begin
            res = opL;
            opL = opS;
            opS = res;
        end
        sigL = (opL.exponent == '0) ? 24'd0 : {1'b1, opL.fraction};
        sigS = (opS.exponent == '0) ? 24'd0 : {1'b1, opS.fraction};
        diff = int'(opL.exponent) - int'(opS.exponent);
        // Far below the rounding point only its presence matters
        if (diff > 40)
        begin
            total = 66'(sigS != '0);
        end
        else
        begin
            total = (66'(sigS) << 40) >> diff;
        end
        if (opL.sign == opS.sign)
        begin
            total = (66'(sigL) << 40) + total;
        end
        else
        begin
            total = (66'(sigL) << 40) - total;
        end
        res = '0;
        if (total == '0)
        begin
            return res;
        end
        msb = 65;
        while (!total[msb])
        begin
            msb--;
        end
        total = total << (65 - msb);
        mant  = {1'b0, total[65:42]};
        if (total[41] && ((|total[40:0]) || total[42]))
        begin
            mant = mant + 25'd1;
        end
        // Bit 63 holds the hidden one of the larger operand
        resExp   = int'(opL.exponent) + msb - 63 + int'(mant[24]);
        res.sign = opL.sign;
        if (resExp >= EXP_MAX)
        begin
            res.exponent = fpExpT'(EXP_MAX);
        end
        else if (resExp > 0)
        begin
            res.exponent = fpExpT'(resExp);
            res.fraction = mant[22:0];
        end
        return res;
    endfunction

    function automatic fp32T randomNormal(input int expCenter, input int expSpan);
        fp32T op;
        int   expVal;
        op     = fp32T'($random(seed));
        expVal = expCenter + ($random(seed) % expSpan);
        op.exponent = fpExpT'((expVal < 1) ? 1 : ((expVal > 254) ? 254 : expVal));
        return op;
    endfunction

    task automatic queueOp(input fpOpReqT req);
        reqQ.push_back(req);
        expQ.push_back(fpAddRef(req));
    endtask

    // Directed case with a result known from the format rules
    task automatic queueKnown(input fp32T a, input fp32T b, input logic sub, input fp32T known);
        fpOpReqT req;
        req.a   = a;
        req.b   = b;
        req.sub = sub;
        assert (fpAddRef(req) == known)
        else
        begin
            $display("ERROR fpAddRef expected %h actual %h", known, fpAddRef(req));
            $display("TEST FAILED");
            $fatal(1, "reference model disagrees with a known case");
        end
        queueOp(req);
    endtask

    // Producer and consumer both act on the falling edge
    always @(negedge clk)
    begin
        if (rstN)
        begin
            if (inCredit)
            begin
                prodCredits++;
            end
            if (outValid)
            begin
                pendingCredits++;
            end
            assert (prodCredits <= IN_CREDITS)
            else stopOnError("inCredit returned more credits than requests were sent");
            assert (pendingCredits <= OUT_CREDITS)
            else stopOnError("outValid sent more results than downstream credits allowed");
            outCredit = 1'b0;
            if (!holdCredits && (pendingCredits > 0) && (($random(seed) & 1) != 0))
            begin
                outCredit = 1'b1;
                pendingCredits--;
            end
            inValid = 1'b0;
            if ((reqQ.size() > 0) && (prodCredits > 0) && (($random(seed) & 3) != 0))
            begin
                inReq   = reqQ.pop_front();
                inValid = 1'b1;
                prodCredits--;
                sentCount++;
            end
        end
    end

    // Results must come back in request order
    always @(negedge clk)
    begin
        fp32T expected;
        if (rstN && outValid)
        begin
            assert (expQ.size() != 0)
            else stopOnError("a result arrived with no request outstanding");
            expected = expQ.pop_front();
            assert (outResult == expected)
            else
            begin
                $display("ERROR outResult expected %h actual %h", expected, outResult);
                $display("TEST FAILED");
                $fatal(1, "result mismatch");
            end
            doneCount++;
        end
    end

    initial
    begin
        fpOpReqT req;
        seed           = 34770;
        rstN           = 1'b0;
        inValid        = 1'b0;
        inReq          = '0;
        outCredit      = 1'b0;
        holdCredits    = 1'b0;
        sentCount      = 0;
        doneCount      = 0;
        prodCredits    = IN_CREDITS;
        pendingCredits = 0;
        // Ties, rounding carry and cancellation
        queueKnown(32'h3F800000, 32'h33800000, 1'b0, 32'h3F800000);
        queueKnown(32'h3F800001, 32'h33800000, 1'b0, 32'h3F800002);
        queueKnown(32'h3FFFFFFF, 32'h33800000, 1'b0, 32'h40000000);
        queueKnown(32'h3F800001, 32'h3F800000, 1'b1, 32'h34000000);
        queueKnown(32'h40490FDB, 32'h40490FDA, 1'b1, 32'h34800000);
        // Zeros, denormals and x - x
        queueKnown(32'h00000000, 32'h3F800000, 1'b0, 32'h3F800000);
        queueKnown(32'h00000001, 32'h3F800000, 1'b1, 32'hBF800000);
        queueKnown(32'h80400000, 32'h00000000, 1'b0, 32'h00000000);
        queueKnown(32'h4123ABCD, 32'h4123ABCD, 1'b1, 32'h00000000);
        // Overflow to infinity and underflow to zero
        queueKnown(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 32'h7F800000);
        queueKnown(32'hFF7FFFFF, 32'hFF000000, 1'b0, 32'hFF800000);
        queueKnown(32'h7F7FFFFF, 32'h73000000, 1'b0, 32'h7F800000);
        queueKnown(32'h00800001, 32'h00800000, 1'b1, 32'h00000000);
        queueKnown(32'h00800000, 32'h00800001, 1'b1, 32'h80000000);
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            req.a = randomNormal(127, 127);
            req.b = (($random(seed) & 1) != 0) ? randomNormal(int'(req.a.exponent), 3)
                                                : randomNormal(127, 127);
            req.sub = ($random(seed) & 1) != 0;
            queueOp(req);
        end
        totalOps = reqQ.size();

        repeat (3) @(negedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        assert (!inCredit && !outValid)
        else stopOnError("inCredit or outValid active right after reset");

        // Block downstream credits until the producer runs dry
        wait (sentCount >= 60);
        @(posedge clk);
        holdCredits = 1'b1;
        repeat (40) @(posedge clk);
        assert (prodCredits == 0)
        else stopOnError("producer still holds credits while downstream is blocked");
        assert (pendingCredits == OUT_CREDITS)
        else stopOnError("results stopped short of the downstream credit limit");
        holdCredits = 1'b0;

        wait (doneCount == totalOps);
        repeat (10) @(posedge clk);
        assert (reqQ.size() == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            stopOnError("requests left unsent after the last result");
        end
    end

    initial
    begin
        wait (totalOps > 0);
        repeat (totalOps * 40 + 500) @(posedge clk);
        $display("Timeout with %0d of %0d results checked", doneCount, totalOps);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== files.f ====
fpFormatPkg.sv
fpPipePkg.sv
fpCreditIssue.sv
fpAlign.sv
fpAddMant.sv
fpNormalize.sv
fpAddTop.sv
fpAddChk.sv
fpAddTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the floating-point add testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fpAddTb -f files.f \
    && ./obj_dir/VfpAddTb > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
